/* common/tester_pkg.sv */
package tester_pkg;

	//////////////////////
	// Widths and sizes
	//////////////////////

	// Width of one input vector and of the signals driven to the device.
	parameter int SIG_W = 32;

	// Bytes per vector frame on the serial line.
	parameter int VEC_BYTES = SIG_W / 8;

	// Number of vectors the on-chip store can hold.
	parameter int MEM_DEPTH = 16;

	typedef logic [7:0] byte_t;
	typedef logic [SIG_W-1:0] vector_t;

	// One extra bit so the write pointer can reach MEM_DEPTH (full).
	typedef logic [$clog2(MEM_DEPTH + 1)-1:0] vec_addr_t;

	// Position inside one test cycle.
	typedef logic [7:0] edge_t;

	//////////////////////
	// Host protocol
	//////////////////////

	parameter byte_t CMD_INPUT = 8'h49;
	parameter byte_t CMD_CONFIG = 8'h43;
	parameter byte_t CMD_EXECUTE = 8'h45;

	parameter byte_t RSP_ACK = 8'h06;
	parameter byte_t RSP_UNKNOWN = 8'h3F;
	parameter byte_t RSP_NO_VECTORS = 8'h4E;

	// Central FSM states.
	typedef enum logic [3:0] {
		S_IDLE,
		S_DECODE,
		S_FRAME,
		S_STORE,
		S_CONFIG,
		S_FETCH,
		S_RUN,
		S_CAPTURE,
		S_TRANSMIT
	} fsm_state_t;

endpackage

/* common/vec_mem_if.sv */
`timescale 1ns/1ps

interface vec_mem_if import tester_pkg::*; ();

	logic wr_en;
	vector_t wdata;
	logic rd_en;
	logic restart;
	vector_t rdata;
	// High while unread vectors remain.
	logic more;

	modport ctrl (output wr_en, output wdata, output rd_en, output restart,
		input rdata, input more);

	modport mem (input wr_en, input wdata, input rd_en, input restart,
		output rdata, output more);

endinterface

/* uart/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx import tester_pkg::*; #(
	parameter int CLKS_PER_BIT = 16
) (
	input logic CLK,
	input logic rst,
	input logic rx,
	output byte_t rx_byte,
	output logic rx_valid
);

	localparam int CW = $clog2(CLKS_PER_BIT);
	localparam logic [CW:0] BIT_LAST = (CW+1)'(CLKS_PER_BIT - 1);
	localparam logic [CW:0] HALF_LAST = (CW+1)'(CLKS_PER_BIT / 2 - 1);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t state;
	logic [CW:0] clk_cnt;
	logic [2:0] bit_idx;
	logic rx_meta;
	logic rx_sync;

	// Two-flop synchronizer, idles high like the line.
	always_ff @(posedge CLK) begin
		if (rst) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= RX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					if (!rx_sync) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					// Recheck at mid start bit to reject glitches.
					if (clk_cnt == HALF_LAST) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						state <= rx_sync ? RX_IDLE : RX_DATA;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (clk_cnt == BIT_LAST) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= RX_STOP;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: begin
					// Bad stop bit drops the byte.
					if (clk_cnt == BIT_LAST) begin
						rx_valid <= rx_sync;
						state <= RX_IDLE;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// LSB arrives first, so shift in from the top.
	always_ff @(posedge CLK) begin
		if (state == RX_DATA && clk_cnt == BIT_LAST) begin
			rx_byte <= {rx_sync, rx_byte[7:1]};
		end
	end

endmodule

/* uart/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx import tester_pkg::*; #(
	parameter int CLKS_PER_BIT = 16
) (
	input logic CLK,
	input logic rst,
	input byte_t tx_byte,
	input logic tx_start,
	output logic tx,
	output logic tx_busy
);

	localparam int CW = $clog2(CLKS_PER_BIT);
	localparam logic [CW:0] BIT_LAST = (CW+1)'(CLKS_PER_BIT - 1);

	logic [CW:0] clk_cnt;
	logic [3:0] bit_idx;
	// Data bits followed by the stop bit.
	logic [8:0] frame;

	always_ff @(posedge CLK) begin
		if (rst) begin
			tx <= 1'b1;
			tx_busy <= 1'b0;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else if (!tx_busy) begin
			if (tx_start) begin
				// Start bit goes out right away.
				tx <= 1'b0;
				tx_busy <= 1'b1;
				clk_cnt <= '0;
				bit_idx <= '0;
			end
		end else if (clk_cnt != BIT_LAST) begin
			clk_cnt <= clk_cnt + 1'b1;
		end else begin
			clk_cnt <= '0;
			if (bit_idx == 4'd9) begin
				// Stop bit has run its full period.
				tx_busy <= 1'b0;
				tx <= 1'b1;
			end else begin
				tx <= frame[0];
				bit_idx <= bit_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (!tx_busy && tx_start) begin
			frame <= {1'b1, tx_byte};
		end else if (tx_busy && clk_cnt == BIT_LAST) begin
			frame <= {1'b1, frame[8:1]};
		end
	end

endmodule

/* verilog/vector_store.sv */
`timescale 1ns/1ps

module vector_store import tester_pkg::*; #(
	parameter int DEPTH = MEM_DEPTH
) (
	input logic CLK,
	input logic rst,
	vec_mem_if.mem mem
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	vector_t store [DEPTH];
	vec_addr_t wr_ptr;
	vec_addr_t rd_ptr;
	logic full;

	assign full = (wr_ptr == vec_addr_t'(DEPTH));

	// Unread entries remain below the write pointer.
	assign mem.more = (rd_ptr < wr_ptr);

	always_ff @(posedge CLK) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (mem.wr_en && !full) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (mem.restart) begin
				rd_ptr <= '0;
			end else if (mem.rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// Array and read register.
	always_ff @(posedge CLK) begin
		if (mem.wr_en && !full) begin
			store[wr_ptr[AW-1:0]] <= mem.wdata;
		end
		if (mem.rd_en) begin
			mem.rdata <= store[rd_ptr[AW-1:0]];
		end
	end

endmodule

/* verilog/cycle_timer.sv */
`timescale 1ns/1ps

module cycle_timer import tester_pkg::*; (
	input logic CLK,
	input logic rst,
	input logic run,
	input edge_t lead,
	input edge_t trail,
	input edge_t len,
	output logic cycle_end,
	output logic prefetch,
	output logic sram_cs_n
);

	edge_t count;
	logic last;
	logic in_window;

	assign last = (count == len - edge_t'(1));
	assign in_window = (count >= lead) && (count < trail);

	// Edge events within the test cycle.
	assign cycle_end = run && last;
	assign prefetch = run && (count == len - edge_t'(2));

	always_ff @(posedge CLK) begin
		if (rst) begin
			count <= '0;
			sram_cs_n <= 1'b1;
		end else if (run) begin
			count <= last ? edge_t'(0) : count + edge_t'(1);
			// Chip select follows the window one register later.
			sram_cs_n <= !in_window;
		end else begin
			count <= '0;
			sram_cs_n <= 1'b1;
		end
	end

endmodule

/* verilog/central_fsm.sv */
`timescale 1ns/1ps

module central_fsm import tester_pkg::*; (
	input logic CLK,
	input logic rst,
	input byte_t rx_byte,
	input logic rx_valid,
	output byte_t tx_byte,
	output logic tx_start,
	input logic tx_busy,
	vec_mem_if.ctrl mem,
	output logic run,
	output edge_t lead,
	output edge_t trail,
	output edge_t len,
	input logic cycle_end,
	input logic prefetch,
	output vector_t signals,
	output logic vt_en
);

	// Counts frame bytes and the three config bytes.
	localparam int BCW = $clog2(VEC_BYTES + 1);

	fsm_state_t state;
	fsm_state_t after_tx;
	byte_t cmd;
	byte_t rsp;
	vector_t vec_buf;
	logic [BCW-1:0] byte_cnt;
	logic fetch_pend;
	logic next_ready;

	////////////////////
	// Strobes
	////////////////////

	assign tx_byte = rsp;
	assign tx_start = (state == S_CAPTURE) && !tx_busy;

	assign mem.wr_en = (state == S_STORE);
	assign mem.wdata = vec_buf;
	assign mem.restart = (state == S_DECODE) && (cmd == CMD_EXECUTE);

	// First read on entry to the test, later reads at prefetch time.
	assign mem.rd_en = mem.more &&
		(((state == S_FETCH) && !fetch_pend) || ((state == S_RUN) && prefetch));

	////////////////////
	// State machine
	////////////////////

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= S_IDLE;
			after_tx <= S_IDLE;
			rsp <= RSP_ACK;
			byte_cnt <= '0;
			fetch_pend <= 1'b0;
			next_ready <= 1'b0;
			run <= 1'b0;
			vt_en <= 1'b0;
			signals <= '0;
			lead <= '0;
			trail <= '0;
			len <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (rx_valid) begin
						state <= S_DECODE;
					end
				end
				S_DECODE: begin
					byte_cnt <= '0;
					case (cmd)
						CMD_INPUT: begin
							// Acknowledge the header, then take the payload.
							rsp <= RSP_ACK;
							after_tx <= S_FRAME;
							state <= S_CAPTURE;
						end
						CMD_CONFIG: begin
							state <= S_CONFIG;
						end
						CMD_EXECUTE: begin
							fetch_pend <= 1'b0;
							state <= S_FETCH;
						end
						default: begin
							rsp <= RSP_UNKNOWN;
							state <= S_CAPTURE;
						end
					endcase
				end
				S_FRAME: begin
					if (rx_valid) begin
						byte_cnt <= byte_cnt + 1'b1;
						if (byte_cnt == BCW'(VEC_BYTES - 1)) begin
							state <= S_STORE;
						end
					end
				end
				S_STORE: begin
					rsp <= RSP_ACK;
					state <= S_CAPTURE;
				end
				S_CONFIG: begin
					if (rx_valid) begin
						byte_cnt <= byte_cnt + 1'b1;
						if (byte_cnt == BCW'(0)) begin
							lead <= rx_byte;
						end else if (byte_cnt == BCW'(1)) begin
							trail <= rx_byte;
						end else begin
							len <= rx_byte;
							rsp <= RSP_ACK;
							state <= S_CAPTURE;
						end
					end
				end
				S_FETCH: begin
					if (!fetch_pend) begin
						if (mem.more) begin
							fetch_pend <= 1'b1;
						end else begin
							rsp <= RSP_NO_VECTORS;
							state <= S_CAPTURE;
						end
					end else begin
						// First vector is on rdata, start the test.
						fetch_pend <= 1'b0;
						next_ready <= 1'b0;
						signals <= mem.rdata;
						vt_en <= 1'b1;
						run <= 1'b1;
						state <= S_RUN;
					end
				end
				S_RUN: begin
					if (prefetch && mem.more) begin
						next_ready <= 1'b1;
					end
					if (cycle_end) begin
						if (next_ready) begin
							signals <= mem.rdata;
							next_ready <= 1'b0;
						end else begin
							// Last vector has had its full cycle.
							signals <= '0;
							vt_en <= 1'b0;
							run <= 1'b0;
							rsp <= RSP_ACK;
							state <= S_CAPTURE;
						end
					end
				end
				S_CAPTURE: begin
					if (!tx_busy) begin
						state <= S_TRANSMIT;
					end
				end
				S_TRANSMIT: begin
					// Done once the stop bit has left the line.
					if (!tx_busy) begin
						state <= after_tx;
						after_tx <= S_IDLE;
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// Command byte and vector frame, LSB byte first.
	always_ff @(posedge CLK) begin
		if (state == S_IDLE && rx_valid) begin
			cmd <= rx_byte;
		end
		if (state == S_FRAME && rx_valid) begin
			vec_buf <= {rx_byte, vec_buf[SIG_W-1:8]};
		end
	end

endmodule

/* verilog/vector_tester_top.sv */
`timescale 1ns/1ps

module vector_tester_top import tester_pkg::*; #(
	parameter int CLKS_PER_BIT = 16,
	parameter int DEPTH = MEM_DEPTH
) (
	input logic CLK,
	input logic rst,
	input logic rx,
	output logic tx,
	output logic sram_cs_n,
	output logic vt_en,
	output vector_t signals
);

	byte_t rx_byte;
	logic rx_valid;
	byte_t tx_byte;
	logic tx_start;
	logic tx_busy;
	logic run;
	edge_t lead;
	edge_t trail;
	edge_t len;
	logic cycle_end;
	logic prefetch;

	vec_mem_if mem_bus ();

	//////////////////////
	// Serial line
	//////////////////////

	uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
		.CLK(CLK), .rst(rst), .rx(rx), .rx_byte(rx_byte), .rx_valid(rx_valid)
	);

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
		.CLK(CLK), .rst(rst), .tx_byte(tx_byte), .tx_start(tx_start),
		.tx(tx), .tx_busy(tx_busy)
	);

	//////////////////////
	// Test engine
	//////////////////////

	vector_store #(.DEPTH(DEPTH)) u_store (
		.CLK(CLK), .rst(rst), .mem(mem_bus.mem)
	);

	cycle_timer u_timer (
		.CLK(CLK), .rst(rst), .run(run), .lead(lead), .trail(trail), .len(len),
		.cycle_end(cycle_end), .prefetch(prefetch), .sram_cs_n(sram_cs_n)
	);

	central_fsm u_fsm (
		.CLK(CLK), .rst(rst),
		.rx_byte(rx_byte), .rx_valid(rx_valid),
		.tx_byte(tx_byte), .tx_start(tx_start), .tx_busy(tx_busy),
		.mem(mem_bus.ctrl),
		.run(run), .lead(lead), .trail(trail), .len(len),
		.cycle_end(cycle_end), .prefetch(prefetch),
		.signals(signals), .vt_en(vt_en)
	);

endmodule

/* tb/tester_chk.sv */
`timescale 1ns/1ps

module tester_chk import tester_pkg::*; (
	input logic CLK,
	input logic rst,
	input logic tx,
	input logic tx_busy,
	input logic sram_cs_n,
	input logic vt_en,
	input vector_t signals
);

	// Chip select only opens inside a running test.
	cs_idle: assert property (@(posedge CLK) disable iff (rst) !vt_en |-> sram_cs_n)
		else $error("sram_cs_n low while vt_en is low");

	// Outputs return to zero once the test ends.
	sig_idle: assert property (@(posedge CLK) disable iff (rst) !vt_en |-> signals == '0)
		else $error("signals not zero while vt_en is low");

	// Line idles high between frames.
	tx_idle: assert property (@(posedge CLK) disable iff (rst) !tx_busy |-> tx)
		else $error("tx low while tx_busy is low");

endmodule

bind vector_tester_top tester_chk u_chk (
	.CLK(CLK), .rst(rst), .tx(tx), .tx_busy(tx_busy),
	.sram_cs_n(sram_cs_n), .vt_en(vt_en), .signals(signals)
);

/* tb/tb_top.sv */
`timescale 1ns/1ps

module tb_top import tester_pkg::*;;

	localparam int CLKS_PER_BIT = 8;
	// Cycles to wait for a response start bit.
	localparam int RSP_TIMEOUT = 5000;

	logic CLK;
	logic rst;
	logic rx;
	logic tx;
	logic sram_cs_n;
	logic vt_en;
	vector_t signals;

	int errors;
	int checks;
	int cfg_lead;
	int cfg_trail;
	int cfg_len;

	// Vectors the DUT should hold, in write order.
	vector_t model[$];
	// Values seen on every cycle with vt_en high.
	vector_t seen_sig[$];
	logic seen_cs[$];

	vector_tester_top #(.CLKS_PER_BIT(CLKS_PER_BIT), .DEPTH(MEM_DEPTH)) DUT (
		.CLK(CLK), .rst(rst), .rx(rx), .tx(tx),
		.sram_cs_n(sram_cs_n), .vt_en(vt_en), .signals(signals)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	always @(negedge CLK) begin
		if (vt_en === 1'b1) begin
			seen_sig.push_back(signals);
			seen_cs.push_back(sram_cs_n);
		end
	end

	////////////////////
	// Helpers
	////////////////////

	task automatic compare_value(input string name, input vector_t got, input vector_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail: %s expected %h got %h", name, exp, got);
		end
	endtask

	task automatic abort_run(input string why);
		errors++;
		$display("Timeout: %s", why);
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("Simulation finished: FAIL");
		$finish;
	endtask

	// Host side of the serial line, start bit first and LSB first.
	task automatic send_byte(input byte_t b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge CLK);
			#1 rx = frame[i];
			repeat (CLKS_PER_BIT - 1) @(posedge CLK);
		end
	endtask

	task automatic recv_byte(output byte_t b);
		int waited;
		waited = 0;
		while (tx !== 1'b0) begin
			@(negedge CLK);
			waited++;
			if (waited > RSP_TIMEOUT) begin
				abort_run("no response start bit on tx");
			end
		end
		// Mid start bit, then mid of each data bit.
		repeat (CLKS_PER_BIT / 2) @(negedge CLK);
		for (int i = 0; i < 8; i++) begin
			repeat (CLKS_PER_BIT) @(negedge CLK);
			b[i] = tx;
		end
		repeat (CLKS_PER_BIT) @(negedge CLK);
		compare_value("tx stop bit", vector_t'(tx), vector_t'(1'b1));
	endtask

	task automatic expect_rsp(input byte_t exp);
		byte_t got;
		recv_byte(got);
		compare_value("rsp", vector_t'(got), vector_t'(exp));
	endtask

	////////////////////
	// Commands
	////////////////////

	task automatic send_unknown();
		byte_t b;
		do begin
			b = byte_t'($urandom);
		end while (b == CMD_INPUT || b == CMD_CONFIG || b == CMD_EXECUTE);
		send_byte(b);
		expect_rsp(RSP_UNKNOWN);
	endtask

	// Legal set keeps lead < trail < len and len of at least 4.
	task automatic send_config();
		cfg_len = 4 + int'($urandom % 17);
		cfg_lead = int'($urandom % (cfg_len - 2));
		cfg_trail = cfg_lead + 1 + int'($urandom % (cfg_len - 1 - cfg_lead));
		send_byte(CMD_CONFIG);
		send_byte(byte_t'(cfg_lead));
		send_byte(byte_t'(cfg_trail));
		send_byte(byte_t'(cfg_len));
		expect_rsp(RSP_ACK);
	endtask

	task automatic send_vector();
		vector_t v;
		v = vector_t'($urandom);
		send_byte(CMD_INPUT);
		expect_rsp(RSP_ACK);
		for (int i = 0; i < VEC_BYTES; i++) begin
			send_byte(v[i*8 +: 8]);
		end
		expect_rsp(RSP_ACK);
		// Writes beyond a full store are dropped.
		if (model.size() < MEM_DEPTH) begin
			model.push_back(v);
		end
	endtask

	task automatic run_execute();
		int cs_low;
		int idx;
		vector_t exp;
		seen_sig.delete();
		seen_cs.delete();
		send_byte(CMD_EXECUTE);
		expect_rsp((model.size() == 0) ? RSP_NO_VECTORS : RSP_ACK);
		compare_value("vt_en high cycles", vector_t'(seen_sig.size()),
			vector_t'(model.size() * cfg_len));
		cs_low = 0;
		if (cfg_len > 0) begin
			for (int c = 0; c < seen_sig.size(); c++) begin
				idx = c / cfg_len;
				exp = (idx < model.size()) ? model[idx] : '0;
				compare_value("signals", seen_sig[c], exp);
				if (seen_cs[c] == 1'b0) begin
					cs_low++;
				end
				// Window length is checked once per test cycle.
				if (c % cfg_len == cfg_len - 1) begin
					compare_value("sram_cs_n low cycles", vector_t'(cs_low),
						vector_t'(cfg_trail - cfg_lead));
					cs_low = 0;
				end
			end
		end
	endtask

	////////////////////
	// Sequence
	////////////////////

	initial begin
		void'($urandom(32'h9f55));
		errors = 0;
		checks = 0;
		cfg_lead = 0;
		cfg_trail = 0;
		cfg_len = 0;
		rst = 1'b1;
		rx = 1'b1;
		repeat (5) @(posedge CLK);
		#1 rst = 1'b0;
		@(negedge CLK);

		compare_value("tx", vector_t'(tx), vector_t'(1'b1));
		compare_value("sram_cs_n", vector_t'(sram_cs_n), vector_t'(1'b1));
		compare_value("vt_en", vector_t'(vt_en), vector_t'(1'b0));
		compare_value("signals", signals, '0);

		// Empty store.
		run_execute();
		repeat (3) send_unknown();

		send_config();
		repeat (5) send_vector();
		run_execute();

		// Overfill the store, then run twice.
		send_config();
		repeat (MEM_DEPTH) send_vector();
		run_execute();
		run_execute();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* tb.f */
common/tester_pkg.sv
common/vec_mem_if.sv
uart/uart_rx.sv
uart/uart_tx.sv
verilog/vector_store.sv
verilog/cycle_timer.sv
verilog/central_fsm.sv
verilog/vector_tester_top.sv
tb/tester_chk.sv
tb/tb_top.sv

/* Makefile */
TOP ?= tb_top
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
SEED_LOG ?= sim.log
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(SEED_LOG) 2>&1; cat $(SEED_LOG)
	@if grep -q "Simulation finished: FAIL" $(SEED_LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(SEED_LOG)

clean:
	rm -rf $(BUILD_DIR) $(SEED_LOG)
